//--- common/memstage_pkg.sv
package memstage_pkg;

    // Data and address widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  wmask_t;    // One enable per byte lane
    typedef logic [15:0] count_t;

    // Memory operation class
    typedef logic [1:0] mem_op_t;
    localparam mem_op_t MEM_OP_NONE   = 2'd0;
    localparam mem_op_t MEM_OP_LOAD   = 2'd1;
    localparam mem_op_t MEM_OP_STORE  = 2'd2;
    localparam mem_op_t MEM_OP_ATOMIC = 2'd3;

    // Access size
    typedef logic [1:0] mem_size_t;
    localparam mem_size_t SIZE_B = 2'd0;
    localparam mem_size_t SIZE_H = 2'd1;
    localparam mem_size_t SIZE_W = 2'd2;

    // Atomic sub-operation, only looked at for MEM_OP_ATOMIC
    typedef logic [3:0] amo_op_t;
    localparam amo_op_t AMO_LR   = 4'd0;
    localparam amo_op_t AMO_SC   = 4'd1;
    localparam amo_op_t AMO_SWAP = 4'd2;
    localparam amo_op_t AMO_ADD  = 4'd3;
    localparam amo_op_t AMO_XOR  = 4'd4;
    localparam amo_op_t AMO_AND  = 4'd5;
    localparam amo_op_t AMO_OR   = 4'd6;
    localparam amo_op_t AMO_MIN  = 4'd7;
    localparam amo_op_t AMO_MAX  = 4'd8;

    // Trap causes raised here, others pass through unchanged
    typedef logic [3:0] cause_t;
    localparam cause_t CAUSE_LOAD_ACCESS_FAULT  = 4'd5;
    localparam cause_t CAUSE_STORE_ACCESS_FAULT = 4'd7;

    // Data RAM geometry and timing
    localparam int RAM_WORDS   = 256;
    localparam int RAM_ADDR_W  = $clog2(RAM_WORDS);      // Word index bits
    localparam int RAM_LATENCY = 2;                      // Accept to response pulse
    localparam int RAM_LAT_W   = $clog2(RAM_LATENCY + 1);

endpackage

//--- mem_stage/store_format.sv
`timescale 1ns/1ns

module store_format
    import memstage_pkg::*;
(
    input  mem_op_t   mem_op,
    input  amo_op_t   amo_op,
    input  mem_size_t mem_size,
    input  logic      is_unsigned,
    input  addr_t     addr,
    input  word_t     rs2_data,
    input  word_t     saved_rdata,
    output word_t     wdata,
    output wmask_t    wmask
);
    logic  less_than;
    word_t amo_result;

    // Old word against operand, signedness picked per instruction
    assign less_than = is_unsigned ? (saved_rdata < rs2_data) :
                                     ($signed(saved_rdata) < $signed(rs2_data));

    always_comb begin
        case (amo_op)
            AMO_SWAP: amo_result = rs2_data;
            AMO_ADD:  amo_result = saved_rdata + rs2_data;
            AMO_XOR:  amo_result = saved_rdata ^ rs2_data;
            AMO_AND:  amo_result = saved_rdata & rs2_data;
            AMO_OR:   amo_result = saved_rdata | rs2_data;
            AMO_MIN:  amo_result = less_than ? saved_rdata : rs2_data;
            AMO_MAX:  amo_result = less_than ? rs2_data : saved_rdata;
            default:  amo_result = rs2_data;   // SC writes the operand as is
        endcase
    end

    always_comb begin
        if (mem_op == MEM_OP_ATOMIC) begin
            // Atomics are always whole aligned words
            wdata = amo_result;
            wmask = 4'b1111;
        end else begin
            wdata = rs2_data << {addr[1:0], 3'b000};
            case (mem_size)
                SIZE_B:  wmask = wmask_t'(4'b0001) << addr[1:0];
                SIZE_H:  wmask = wmask_t'(4'b0011) << addr[1:0];
                default: wmask = 4'b1111;
            endcase
        end
    end

endmodule

//--- mem_stage/load_format.sv
`timescale 1ns/1ns

module load_format
    import memstage_pkg::*;
(
    input  mem_op_t   mem_op,
    input  amo_op_t   amo_op,
    input  mem_size_t mem_size,
    input  logic      is_unsigned,
    input  logic      sc_succeeded,
    input  word_t     saved_rdata,
    output word_t     rdata
);
    logic sign_b;
    logic sign_h;

    // Sign bits of the low lanes, already shifted down by the controller
    assign sign_b = !is_unsigned && saved_rdata[7];
    assign sign_h = !is_unsigned && saved_rdata[15];

    always_comb begin
        if (mem_op == MEM_OP_ATOMIC) begin
            if (amo_op == AMO_SC) begin
                rdata = sc_succeeded ? 32'd0 : 32'd1;
            end else begin
                rdata = saved_rdata;          // LR and AMOs return the old word
            end
        end else begin
            case (mem_size)
                SIZE_B:  rdata = {{24{sign_b}}, saved_rdata[7:0]};
                SIZE_H:  rdata = {{16{sign_h}}, saved_rdata[15:0]};
                default: rdata = saved_rdata;
            endcase
        end
    end

endmodule

//--- mem_stage/mem_stage_ctrl.sv
`timescale 1ns/1ns

module mem_stage_ctrl
    import memstage_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      valid,
    input  logic      is_new,
    input  logic      trap_in_valid,
    input  cause_t    trap_in_cause,
    input  mem_op_t   mem_op,
    input  mem_size_t mem_size,
    input  logic      is_unsigned,
    input  amo_op_t   amo_op,
    input  addr_t     addr,
    input  word_t     rs2_data,
    input  logic      req_ready,
    input  logic      resp_valid,
    input  word_t     resp_rdata,
    input  logic      resp_error,
    output logic      req_valid,
    output logic      req_wen,
    output addr_t     req_addr,
    output word_t     req_wdata,
    output wmask_t    req_wmask,
    output logic      trap_out_valid,
    output cause_t    trap_out_cause,
    output word_t     rdata,
    output logic      stall
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_READY,
        ST_WAIT_READ,
        ST_WAIT_WRITE
    } state_t;

    state_t state;
    logic   cmd_done;       // Access finished, result held until retire
    logic   replaced;       // AMO has moved on to its store phase
    logic   res_valid;
    addr_t  res_addr;
    logic   sc_succeeded;
    word_t  saved_rdata;    // Lane-shifted read word
    logic   saved_error;

    logic is_atomic;
    logic is_amo_rmw;
    logic sc_executable;
    logic is_store;
    logic is_store_cmd;
    logic mem_trap;

    assign is_atomic     = mem_op == MEM_OP_ATOMIC;
    assign is_amo_rmw    = is_atomic && amo_op != AMO_LR && amo_op != AMO_SC;
    assign sc_executable = res_valid && res_addr == addr;

    // Direction of the access currently being issued
    assign is_store = mem_op == MEM_OP_STORE ||
                      (is_atomic && (amo_op == AMO_SC || (replaced && state != ST_IDLE)));

    // Fault class, LR counts as a load and every other atomic as a store
    assign is_store_cmd = mem_op == MEM_OP_STORE || (is_atomic && amo_op != AMO_LR);

    assign req_valid = valid && !trap_in_valid && state == ST_WAIT_READY;
    assign req_wen   = is_store;
    assign req_addr  = {addr[31:2], 2'b00};

    assign stall = valid && !trap_in_valid &&
                   (state != ST_IDLE || (is_new && mem_op != MEM_OP_NONE));

    // Trap merge
    assign mem_trap = valid && mem_op != MEM_OP_NONE && state == ST_IDLE &&
                      !is_new && cmd_done && saved_error;
    assign trap_out_valid = trap_in_valid || mem_trap;
    assign trap_out_cause = (trap_in_valid || !mem_trap) ? trap_in_cause :
                            is_store_cmd ? CAUSE_STORE_ACCESS_FAULT : CAUSE_LOAD_ACCESS_FAULT;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            cmd_done     <= 1'b0;
            replaced     <= 1'b0;
            res_valid    <= 1'b0;
            sc_succeeded <= 1'b0;
            saved_error  <= 1'b0;
        end else if (!valid || trap_in_valid) begin
            state       <= ST_IDLE;   // Abort or empty slot
            cmd_done    <= 1'b0;
            replaced    <= 1'b0;
            saved_error <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (is_new) begin
                    replaced    <= 1'b0;
                    saved_error <= 1'b0;
                    cmd_done    <= 1'b0;
                    if (mem_op != MEM_OP_NONE) begin
                        if (is_atomic && amo_op == AMO_SC) begin
                            res_valid    <= 1'b0;     // SC always drops the reservation
                            sc_succeeded <= sc_executable;
                            if (sc_executable) begin
                                state <= ST_WAIT_READY;
                            end else begin
                                cmd_done <= 1'b1;     // Fails without touching memory
                            end
                        end else begin
                            if (is_atomic && amo_op == AMO_LR) begin
                                res_valid <= 1'b1;
                                res_addr  <= addr;
                            end
                            state <= ST_WAIT_READY;
                        end
                    end
                end
                ST_WAIT_READY: if (req_ready) begin
                    state <= is_store ? ST_WAIT_WRITE : ST_WAIT_READ;
                end
                ST_WAIT_READ: if (resp_valid) begin
                    saved_rdata <= resp_rdata >> {addr[1:0], 3'b000};
                    saved_error <= resp_error;
                    if (is_amo_rmw && !resp_error) begin
                        state    <= ST_WAIT_READY;    // Second pass writes the result
                        replaced <= 1'b1;
                    end else begin
                        state    <= ST_IDLE;
                        cmd_done <= 1'b1;
                    end
                end
                ST_WAIT_WRITE: if (resp_valid) begin
                    saved_error <= resp_error;
                    state       <= ST_IDLE;
                    cmd_done    <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    store_format store_fmt_i (
        .mem_op      (mem_op),
        .amo_op      (amo_op),
        .mem_size    (mem_size),
        .is_unsigned (is_unsigned),
        .addr        (addr),
        .rs2_data    (rs2_data),
        .saved_rdata (saved_rdata),
        .wdata       (req_wdata),
        .wmask       (req_wmask)
    );

    load_format load_fmt_i (
        .mem_op       (mem_op),
        .amo_op       (amo_op),
        .mem_size     (mem_size),
        .is_unsigned  (is_unsigned),
        .sc_succeeded (sc_succeeded),
        .saved_rdata  (saved_rdata),
        .rdata        (rdata)
    );

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ns

module data_ram
    import memstage_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   req_valid,
    input  logic   req_wen,
    input  addr_t  req_addr,
    input  word_t  req_wdata,
    input  wmask_t req_wmask,
    output logic   req_ready,
    output logic   resp_valid,
    output word_t  resp_rdata,
    output logic   resp_error
);
    word_t mem [RAM_WORDS];

    logic                 pending;    // One access in flight
    logic [RAM_LAT_W-1:0] lat_cnt;
    logic                 hold_wen;
    addr_t                hold_addr;
    word_t                hold_wdata;
    wmask_t               hold_wmask;

    logic                  accept;
    logic                  finish;
    logic                  in_range;
    logic [RAM_ADDR_W-1:0] word_idx;

    assign req_ready = !pending;
    assign accept    = req_valid && req_ready;
    assign finish    = pending && lat_cnt == '0;
    assign in_range  = hold_addr[31:RAM_ADDR_W + 2] == '0;
    assign word_idx  = hold_addr[RAM_ADDR_W + 1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            pending    <= 1'b0;
            lat_cnt    <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= finish;     // Single-cycle pulse
            if (accept) begin
                pending <= 1'b1;
                lat_cnt <= RAM_LAT_W'(RAM_LATENCY - 1);
            end else if (finish) begin
                pending <= 1'b0;
            end else if (pending) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    // Request capture
    always_ff @(posedge clk) begin
        if (accept) begin
            hold_wen   <= req_wen;
            hold_addr  <= req_addr;
            hold_wdata <= req_wdata;
            hold_wmask <= req_wmask;
        end
    end

    // Array access at completion, faulting accesses leave memory alone
    always_ff @(posedge clk) begin
        if (finish) begin
            if (in_range) begin
                if (hold_wen) begin
                    for (int b = 0; b < 4; b++) begin
                        if (hold_wmask[b]) begin
                            mem[word_idx][8*b +: 8] <= hold_wdata[8*b +: 8];
                        end
                    end
                end
                resp_rdata <= mem[word_idx];
                resp_error <= 1'b0;
            end else begin
                resp_rdata <= '0;
                resp_error <= 1'b1;
            end
        end
    end

endmodule

//--- src/stall_counter.sv
`timescale 1ns/1ns

module stall_counter
    import memstage_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   stall,
    input  logic   count_clear,
    output count_t stall_count
);
    logic at_max;

    assign at_max = stall_count == '1;

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_count <= '0;
        end else if (count_clear) begin
            stall_count <= '0;                       // Clear wins over counting
        end else if (stall && !at_max) begin
            stall_count <= stall_count + count_t'(1); // Saturates at all ones
        end
    end

endmodule

//--- src/mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top
    import memstage_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      valid,
    input  logic      is_new,
    input  logic      trap_in_valid,
    input  cause_t    trap_in_cause,
    input  mem_op_t   mem_op,
    input  mem_size_t mem_size,
    input  logic      is_unsigned,
    input  amo_op_t   amo_op,
    input  addr_t     addr,
    input  word_t     rs2_data,
    input  logic      count_clear,
    output logic      trap_out_valid,
    output cause_t    trap_out_cause,
    output word_t     rdata,
    output logic      stall,
    output count_t    stall_count
);
    // Stage to RAM request and response
    logic   req_valid;
    logic   req_wen;
    addr_t  req_addr;
    word_t  req_wdata;
    wmask_t req_wmask;
    logic   req_ready;
    logic   resp_valid;
    word_t  resp_rdata;
    logic   resp_error;

    mem_stage_ctrl mem_stage_i (
        .clk            (clk),
        .rst            (rst),
        .valid          (valid),
        .is_new         (is_new),
        .trap_in_valid  (trap_in_valid),
        .trap_in_cause  (trap_in_cause),
        .mem_op         (mem_op),
        .mem_size       (mem_size),
        .is_unsigned    (is_unsigned),
        .amo_op         (amo_op),
        .addr           (addr),
        .rs2_data       (rs2_data),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .resp_error     (resp_error),
        .req_valid      (req_valid),
        .req_wen        (req_wen),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_wmask      (req_wmask),
        .trap_out_valid (trap_out_valid),
        .trap_out_cause (trap_out_cause),
        .rdata          (rdata),
        .stall          (stall)
    );

    data_ram data_ram_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_wen    (req_wen),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_error (resp_error)
    );

    stall_counter stall_counter_i (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .count_clear (count_clear),
        .stall_count (stall_count)
    );

endmodule

//--- sim/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem
    import memstage_pkg::*;
();
    localparam int STALL_TIMEOUT = 50;   // Longer than any AMO takes

    logic      clk;
    logic      rst;
    logic      valid;
    logic      is_new;
    logic      trap_in_valid;
    cause_t    trap_in_cause;
    mem_op_t   mem_op;
    mem_size_t mem_size;
    logic      is_unsigned;
    amo_op_t   amo_op;
    addr_t     addr;
    word_t     rs2_data;
    logic      count_clear;
    logic      trap_out_valid;
    cause_t    trap_out_cause;
    word_t     rdata;
    logic      stall;
    count_t    stall_count;

    logic [7:0]  shadow [1024];   // Byte image of the RAM
    logic [31:0] lcg_state;
    int          value_errors;
    int          timeout_errors;
    word_t       res_rdata;       // Sampled when stall falls
    logic        res_trap;
    cause_t      res_cause;

    mem_subsystem_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .valid          (valid),
        .is_new         (is_new),
        .trap_in_valid  (trap_in_valid),
        .trap_in_cause  (trap_in_cause),
        .mem_op         (mem_op),
        .mem_size       (mem_size),
        .is_unsigned    (is_unsigned),
        .amo_op         (amo_op),
        .addr           (addr),
        .rs2_data       (rs2_data),
        .count_clear    (count_clear),
        .trap_out_valid (trap_out_valid),
        .trap_out_cause (trap_out_cause),
        .rdata          (rdata),
        .stall          (stall),
        .stall_count    (stall_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        return {shadow[{a[9:2], 2'd3}], shadow[{a[9:2], 2'd2}],
                shadow[{a[9:2], 2'd1}], shadow[{a[9:2], 2'd0}]};
    endfunction

    // Loaded value after extension from the byte image
    function automatic word_t expected_load(input addr_t a, input mem_size_t size,
                                            input logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        b = shadow[a[9:0]];
        h = {shadow[a[9:0] + 10'd1], shadow[a[9:0]]};
        case (size)
            SIZE_B:  return uns ? {24'd0, b} : {{24{b[7]}}, b};
            SIZE_H:  return uns ? {16'd0, h} : {{16{h[15]}}, h};
            default: return shadow_word(a);
        endcase
    endfunction

    // Combined value written back by an AMO
    function automatic word_t amo_expect(input amo_op_t op, input logic uns,
                                         input word_t old, input word_t opnd);
        word_t flip;
        logic  lt;
        flip = uns ? 32'd0 : 32'h8000_0000;   // Signed order via flipped sign bits
        lt   = (old ^ flip) < (opnd ^ flip);
        case (op)
            AMO_ADD: return old + opnd;
            AMO_XOR: return old ^ opnd;
            AMO_AND: return old & opnd;
            AMO_OR:  return old | opnd;
            AMO_MIN: return lt ? old : opnd;
            AMO_MAX: return lt ? opnd : old;
            default: return opnd;             // Swap
        endcase
    endfunction

    task automatic put_shadow(input addr_t a, input mem_size_t size, input word_t d);
        case (size)
            SIZE_B: shadow[a[9:0]] = d[7:0];
            SIZE_H: begin
                shadow[a[9:0]]         = d[7:0];
                shadow[a[9:0] + 10'd1] = d[15:8];
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    shadow[{a[9:2], 2'd0} + 10'(k)] = d[8*k +: 8];
                end
            end
        endcase
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %s = %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_trap(input logic exp_valid, input cause_t exp_cause);
        check_value("trap_out_valid", {31'd0, res_trap}, {31'd0, exp_valid});
        if (exp_valid) begin
            check_value("trap_out_cause", {28'd0, res_cause}, {28'd0, exp_cause});
        end
    endtask

    // One instruction held until stall falls and then retired
    task automatic do_access(input mem_op_t op, input mem_size_t size, input logic uns,
                             input amo_op_t aop, input addr_t a, input word_t d,
                             input logic trap_in, input cause_t cause_in);
        int   n;
        logic fell;
        @(negedge clk);
        valid         = 1'b1;
        is_new        = 1'b1;
        mem_op        = op;
        mem_size      = size;
        is_unsigned   = uns;
        amo_op        = aop;
        addr          = a;
        rs2_data      = d;
        trap_in_valid = trap_in;
        trap_in_cause = cause_in;
        @(negedge clk);
        is_new = 1'b0;
        fell   = 1'b0;
        n      = 0;
        while (!fell && n < STALL_TIMEOUT) begin
            @(negedge clk);
            fell = !stall;
            n++;
        end
        assert (fell) else begin
            $display("Timeout: stall still high after %0d cycles at address %h",
                     STALL_TIMEOUT, a);
            timeout_errors++;
        end
        res_rdata     = rdata;
        res_trap      = trap_out_valid;
        res_cause     = trap_out_cause;
        valid         = 1'b0;            // Retire
        trap_in_valid = 1'b0;
        mem_op        = MEM_OP_NONE;
    endtask

    task automatic store_mem(input addr_t a, input mem_size_t size, input word_t d);
        do_access(MEM_OP_STORE, size, 1'b0, AMO_LR, a, d, 1'b0, 4'd0);
        check_trap(1'b0, 4'd0);
        put_shadow(a, size, d);
    endtask

    task automatic load_check(input addr_t a, input mem_size_t size, input logic uns);
        do_access(MEM_OP_LOAD, size, uns, AMO_LR, a, 32'd0, 1'b0, 4'd0);
        check_value("rdata", res_rdata, expected_load(a, size, uns));
        check_trap(1'b0, 4'd0);
    endtask

    task automatic clear_counter();
        @(negedge clk);
        count_clear = 1'b1;
        @(negedge clk);
        count_clear = 1'b0;
    endtask

    task automatic reset_state();
        check_value("stall", {31'd0, stall}, 32'd0);
        check_value("trap_out_valid", {31'd0, trap_out_valid}, 32'd0);
        check_value("stall_count", {16'd0, stall_count}, 32'd0);
    endtask

    task automatic sizes_and_lanes();
        addr_t base [8];
        word_t r;
        for (int i = 0; i < 8; i++) begin
            r       = next_rand();
            base[i] = {22'd0, r[9:2], 2'b00};
            store_mem(base[i], SIZE_W, next_rand());
        end
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            store_mem(base[i] + {30'd0, r[1:0]}, SIZE_B, next_rand());
            r = next_rand();
            store_mem(base[i] + {30'd0, r[0], 1'b0}, SIZE_H, next_rand());
        end
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 4; k++) begin
                load_check(base[i] + k, SIZE_B, 1'b0);
                load_check(base[i] + k, SIZE_B, 1'b1);
                if (k % 2 == 0) begin
                    load_check(base[i] + k, SIZE_H, 1'b0);
                    load_check(base[i] + k, SIZE_H, 1'b1);
                end
            end
            load_check(base[i], SIZE_W, 1'b0);
        end
    endtask

    task automatic reservation_sequence();
        addr_t a;
        addr_t b;
        word_t d;
        a = 32'h0000_0200;
        b = 32'h0000_0240;
        store_mem(a, SIZE_W, next_rand());
        store_mem(b, SIZE_W, next_rand());
        do_access(MEM_OP_ATOMIC, SIZE_W, 1'b0, AMO_LR, a, 32'd0, 1'b0, 4'd0);
        check_value("rdata", res_rdata, shadow_word(a));
        d = next_rand();
        do_access(MEM_OP_ATOMIC, SIZE_W, 1'b0, AMO_SC, a, d, 1'b0, 4'd0);
        check_value("rdata", res_rdata, 32'd0);     // SC success
        put_shadow(a, SIZE_W, d);
        load_check(a, SIZE_W, 1'b0);
        do_access(MEM_OP_ATOMIC, SIZE_W, 1'b0, AMO_SC, a, next_rand(), 1'b0, 4'd0);
        check_value("rdata", res_rdata, 32'd1);     // Reservation already gone
        load_check(a, SIZE_W, 1'b0);
        do_access(MEM_OP_ATOMIC, SIZE_W, 1'b0, AMO_LR, a, 32'd0, 1'b0, 4'd0);
        do_access(MEM_OP_ATOMIC, SIZE_W, 1'b0, AMO_SC, b, next_rand(), 1'b0, 4'd0);
        check_value("rdata", res_rdata, 32'd1);
        load_check(b, SIZE_W, 1'b0);
        do_access(MEM_OP_ATOMIC, SIZE_W, 1'b0, AMO_SC, a, next_rand(), 1'b0, 4'd0);
        check_value("rdata", res_rdata, 32'd1);     // Cleared by the failed SC
        load_check(a, SIZE_W, 1'b0);
    endtask

    task automatic amo_operations();
        amo_op_t op_list [7];
        addr_t   a;
        word_t   old;
        word_t   opnd;
        op_list = '{AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND, AMO_OR, AMO_MIN, AMO_MAX};
        for (int o = 0; o < 7; o++) begin
            for (int u = 0; u < 2; u++) begin
                a    = 32'h0000_0300 + addr_t'(8 * o + 4 * u);
                old  = next_rand();
                opnd = next_rand();
                opnd[31] = ~old[31];                // Signed and unsigned order differ
                store_mem(a, SIZE_W, old);
                do_access(MEM_OP_ATOMIC, SIZE_W, u[0], op_list[o], a, opnd, 1'b0, 4'd0);
                check_value("rdata", res_rdata, old);
                check_trap(1'b0, 4'd0);
                put_shadow(a, SIZE_W, amo_expect(op_list[o], u[0], old, opnd));
                load_check(a, SIZE_W, 1'b0);
            end
        end
    endtask

    task automatic access_faults();
        addr_t a;
        do_access(MEM_OP_LOAD, SIZE_W, 1'b0, AMO_LR, 32'h0000_0400, 32'd0, 1'b0, 4'd0);
        check_trap(1'b1, CAUSE_LOAD_ACCESS_FAULT);
        do_access(MEM_OP_ATOMIC, SIZE_W, 1'b0, AMO_LR, 32'h0000_0800, 32'd0, 1'b0, 4'd0);
        check_trap(1'b1, CAUSE_LOAD_ACCESS_FAULT);
        do_access(MEM_OP_STORE, SIZE_W, 1'b0, AMO_LR, 32'h8000_0010, next_rand(),
                  1'b0, 4'd0);
        check_trap(1'b1, CAUSE_STORE_ACCESS_FAULT);
        do_access(MEM_OP_ATOMIC, SIZE_W, 1'b0, AMO_ADD, 32'h0000_0ffc, next_rand(),
                  1'b0, 4'd0);
        check_trap(1'b1, CAUSE_STORE_ACCESS_FAULT);
        // Trap from an earlier stage keeps the store out of memory
        a = 32'h0000_0380;
        store_mem(a, SIZE_W, next_rand());
        clear_counter();
        do_access(MEM_OP_STORE, SIZE_W, 1'b0, AMO_LR, a, next_rand(), 1'b1, 4'd2);
        check_trap(1'b1, 4'd2);
        check_value("stall_count", {16'd0, stall_count}, 32'd0);
        load_check(a, SIZE_W, 1'b0);
        do_access(MEM_OP_LOAD, SIZE_B, 1'b0, AMO_LR, a, 32'd0, 1'b1, 4'd13);
        check_trap(1'b1, 4'd13);
    endtask

    task automatic stall_count_plain_load();
        store_mem(32'h0000_0100, SIZE_W, next_rand());
        clear_counter();
        load_check(32'h0000_0100, SIZE_W, 1'b0);
        check_value("stall_count", {16'd0, stall_count}, word_t'(3 + RAM_LATENCY));
    endtask

    initial begin
        lcg_state      = 32'd39658;
        value_errors   = 0;
        timeout_errors = 0;
        rst            = 1'b1;
        valid          = 1'b0;
        is_new         = 1'b0;
        trap_in_valid  = 1'b0;
        trap_in_cause  = 4'd0;
        mem_op         = MEM_OP_NONE;
        mem_size       = SIZE_W;
        is_unsigned    = 1'b0;
        amo_op         = AMO_LR;
        addr           = 32'd0;
        rs2_data       = 32'd0;
        count_clear    = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        reset_state();
        sizes_and_lanes();
        reservation_sequence();
        amo_operations();
        access_faults();
        stall_count_plain_load();

        $display("Checks done: %0d value errors, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- mem_subsystem.f
common/memstage_pkg.sv
mem_stage/store_format.sv
mem_stage/load_format.sv
mem_stage/mem_stage_ctrl.sv
src/data_ram.sv
src/stall_counter.sv
src/mem_subsystem_top.sv
sim/tb_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
    --top-module tb_mem_subsystem -f mem_subsystem.f -o tb_mem_subsystem

./obj_dir/tb_mem_subsystem > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
